//--- compile.f
source/cond_cfg_pkg.sv
source/setup_word_filter.sv
source/sync_fifo.sv
source/cond_cfg_ctrl.sv
source/cond_field_assembler.sv
source/filter_cond_cfg_loader.sv
verif/filter_cond_cfg_loader_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
verilator --binary --timing --assert -j 0 -f compile.f \
    --top-module filter_cond_cfg_loader_tb -o filter_cond_cfg_loader_sim \
    && ./obj_dir/filter_cond_cfg_loader_sim | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verif/filter_cond_cfg_loader_tb.sv
/*
 * Testbench for the filter condition configuration loader
 * Sends setup word sequences, models the slot table and checks every configuration
 */
`timescale 1ns/1ns
`default_nettype none

module filter_cond_cfg_loader_tb
    import cond_cfg_pkg::*;
();

    localparam int          SEQ_LEN        = 8;
    localparam int          ENGINE_SLOT    = 1;
    localparam int          SEQ_BASE       = ENGINE_SLOT * SEQ_LEN;
    localparam logic [31:0] SEED           = 32'h5aa575e7;
    localparam int          TIMEOUT_CYCLES = 400;

    logic        ap_clk = 1'b0;
    logic        rst;
    mem_packet_t mem_in;
    logic        cfg_rd_en;
    cond_cfg_t   cfg_out;
    logic        cfg_valid;

    logic [31:0] lfsr_state;
    mem_word_t   seq_words [SEQ_LEN];
    cond_cfg_t   model_cfg;
    cond_cfg_t   head_cfg;
    cond_cfg_t   exp_q [$];
    int          model_pos;
    logic        hold_reads;
    string       test_name;

    filter_cond_cfg_loader #(
        .SEQ_LEN(SEQ_LEN), .ENGINE_SLOT(ENGINE_SLOT), .FIFO_DEPTH(16)
    ) filter_cond_cfg_loader_i (
        .ap_clk(ap_clk), .rst(rst), .mem_in(mem_in), .cfg_rd_en(cfg_rd_en),
        .cfg_out(cfg_out), .cfg_valid(cfg_valid)
    );

    always #20 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [64:0] expected,
                                   input logic [64:0] actual);
        $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_failure(input string msg);
        $display("%s during %s", msg, test_name);
        stop_with_failure();
    endtask

    // ------------------------------------------------------------------------
    // Random fields
    // ------------------------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] next_random(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic fill_sequence();
        mem_word_t  upper;
        logic [3:0] op;
        upper = next_random(32);
        // Only defined operation codes
        op = 4'(next_random(3) % 7);
        seq_words[0] = {upper[31:4], op};
        for (int k = 1; k < SEQ_LEN; k++) begin
            seq_words[k] = next_random(32);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model of the slot table
    // ------------------------------------------------------------------------
    task automatic model_accept(input int index, input mem_word_t data);
        if (index == SEQ_BASE) begin
            model_pos = 0;
        end else if (model_pos >= 0) begin
            model_pos = model_pos + 1;
        end
        case (model_pos)
            0: model_cfg.filter_op   = filter_op_e'(data[3:0]);
            1: model_cfg.filter_mask = data[3:0];
            2: model_cfg.const_mask  = data[3:0];
            3: model_cfg.const_value = data;
            4: model_cfg.ops_mask    = data[15:0];
            5: begin
                model_cfg.flags.break_flag       = data[0];
                model_cfg.flags.filter_post      = data[1];
                model_cfg.flags.continue_flag    = data[2];
                model_cfg.flags.ternary_flag     = data[3];
                model_cfg.flags.conditional_flag = data[4];
            end
            default: ;
        endcase
        if (model_pos == SEQ_LEN - 1) begin
            exp_q.push_back(model_cfg);
            model_pos = -1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic send_word(input buffer_kind_e kind, input int index, input int shift_amt,
                             input mem_word_t data);
        @(negedge ap_clk);
        mem_in.valid  = 1'b1;
        mem_in.kind   = kind;
        mem_in.offset = addr_offset_t'(index << shift_amt);
        mem_in.shift  = SHIFT_W'(shift_amt);
        mem_in.data   = data;
        if (kind != KIND_OTHER && index >= SEQ_BASE && index < SEQ_BASE + SEQ_LEN) begin
            model_accept(index, data);
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge ap_clk);
            mem_in = '0;
        end
    endtask

    // Junk words are foreign kinds and indices below and above the window
    task automatic send_sequence(input int shift_amt, input bit with_junk, input int count);
        for (int k = 0; k < count; k++) begin
            if (with_junk) begin
                send_word(KIND_OTHER, SEQ_BASE + k, shift_amt, next_random(32));
                send_word(KIND_ENGINE_SETUP, k, shift_amt, next_random(32));
                send_word(KIND_CU_SETUP, SEQ_BASE + SEQ_LEN + 3 * k, shift_amt,
                          next_random(32));
            end
            send_word((k % 2 == 0) ? KIND_CU_SETUP : KIND_ENGINE_SETUP, SEQ_BASE + k,
                      shift_amt, seq_words[k]);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("Timeout waiting for the expected configurations");
            end
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge ap_clk);
            assert (cfg_valid === 1'b0)
                else report_mismatch("cfg_valid", 65'd0, 65'(cfg_valid));
        end
    endtask

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    assert property (@(posedge ap_clk) rst |=> !cfg_valid)
        else report_failure("cfg_valid was high right after reset");

    assert property (@(posedge ap_clk) disable iff (rst) hold_reads |-> !cfg_valid)
        else report_failure("cfg_valid appeared while reads were held off");

    always @(posedge ap_clk) begin
        if (!rst && cfg_valid) begin
            assert (exp_q.size() != 0)
                else report_failure("cfg_valid arrived with no configuration expected");
            if (exp_q.size() != 0) begin
                head_cfg = exp_q.pop_front();
                assert (cfg_out === head_cfg)
                    else report_mismatch("cfg_out", head_cfg, cfg_out);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int cycles;
        lfsr_state = SEED;
        rst        = 1'b1;
        cfg_rd_en  = 1'b0;
        mem_in     = '0;
        model_cfg  = '0;
        model_pos  = -1;
        hold_reads = 1'b0;
        test_name  = "reset";
        repeat (10) @(posedge ap_clk);
        @(negedge ap_clk);
        rst = 1'b0;

        test_name = "idle_after_reset";
        check_quiet(20);

        test_name = "in_order_sequence";
        cfg_rd_en = 1'b1;
        fill_sequence();
        send_sequence(0, 1'b0, SEQ_LEN);
        drive_idle(1);
        wait_for_drain();

        test_name = "ignored_words";
        fill_sequence();
        send_sequence(0, 1'b1, SEQ_LEN);
        drive_idle(1);
        wait_for_drain();
        check_quiet(20);

        test_name = "shifted_offsets";
        fill_sequence();
        send_sequence(2, 1'b0, SEQ_LEN);
        drive_idle(1);
        wait_for_drain();

        // Three configurations park in the output FIFO
        test_name  = "held_readout";
        cfg_rd_en  = 1'b0;
        hold_reads = 1'b1;
        repeat (3) begin
            fill_sequence();
            send_sequence(0, 1'b0, SEQ_LEN);
        end
        drive_idle(40);
        @(negedge ap_clk);
        cfg_rd_en  = 1'b1;
        hold_reads = 1'b0;
        cycles     = 0;
        while (cfg_valid !== 1'b1) begin
            @(negedge ap_clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_failure("Timeout waiting for cfg_valid after cfg_rd_en");
            end
        end
        assert (cycles == 3) else report_mismatch("read latency", 65'(3), 65'(cycles));
        wait_for_drain();

        test_name = "restart_partial";
        fill_sequence();
        send_sequence(0, 1'b0, 5);
        drive_idle(3);
        fill_sequence();
        send_sequence(0, 1'b0, SEQ_LEN);
        drive_idle(1);
        wait_for_drain();
        check_quiet(30);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/filter_cond_cfg_loader.sv
/*
 * Filter condition configuration loader
 * Filters setup responses, assembles filter conditions and queues them for readout
 */
`timescale 1ns/1ns
`default_nettype none

module filter_cond_cfg_loader
    import cond_cfg_pkg::*;
#(
    parameter int SEQ_LEN     = 8,
    parameter int ENGINE_SLOT = 0,
    parameter int FIFO_DEPTH  = 16
) (
    input  logic        ap_clk,
    input  logic        rst,
    input  mem_packet_t mem_in,
    input  logic        cfg_rd_en,
    output cond_cfg_t   cfg_out,
    output logic        cfg_valid
);

    mem_word_t          filt_word;
    logic               filt_push;
    logic               filt_first;
    logic [DATA_W:0]    resp_dout;
    logic               resp_pop;
    logic               resp_valid;
    logic               resp_empty;
    logic [SEQ_LEN-1:0] slot;
    logic               capture;
    logic               complete;
    cond_cfg_t          asm_cfg;
    logic               asm_push;
    cond_cfg_t          out_dout;
    logic               out_rd_en;
    logic               out_valid;
    logic               out_empty;
    logic               out_almost_full;
    logic               rd_en_q;

    // ------------------------------------------------------------------------
    // Response path
    // ------------------------------------------------------------------------
    setup_word_filter #(.SEQ_LEN(SEQ_LEN), .ENGINE_SLOT(ENGINE_SLOT)) filter_i (
        .ap_clk(ap_clk), .rst(rst), .mem_in(mem_in),
        .push(filt_push), .word(filt_word), .word_is_first(filt_first)
    );

    // First-word flag rides above the data word
    sync_fifo #(.WIDTH(DATA_W + 1), .DEPTH(FIFO_DEPTH)) resp_fifo_i (
        .ap_clk(ap_clk), .rst(rst), .wr_en(filt_push), .din({filt_first, filt_word}),
        .rd_en(resp_pop), .dout(resp_dout), .dout_valid(resp_valid),
        .empty(resp_empty), .almost_full()
    );

    cond_cfg_ctrl #(.SEQ_LEN(SEQ_LEN)) ctrl_i (
        .ap_clk(ap_clk), .rst(rst), .resp_empty(resp_empty), .resp_valid(resp_valid),
        .resp_first(resp_dout[DATA_W]), .out_almost_full(out_almost_full),
        .resp_pop(resp_pop), .slot(slot), .capture(capture), .complete(complete)
    );

    cond_field_assembler assembler_i (
        .ap_clk(ap_clk), .word(resp_dout[DATA_W-1:0]), .slot(slot[CFG_WORDS-1:0]),
        .capture(capture), .complete(complete), .cfg_push(asm_push), .cfg(asm_cfg)
    );

    // ------------------------------------------------------------------------
    // Configuration output
    // ------------------------------------------------------------------------
    assign out_rd_en = rd_en_q & ~out_empty;

    sync_fifo #(.WIDTH($bits(cond_cfg_t)), .DEPTH(FIFO_DEPTH)) cfg_fifo_i (
        .ap_clk(ap_clk), .rst(rst), .wr_en(asm_push), .din(asm_cfg),
        .rd_en(out_rd_en), .dout(out_dout), .dout_valid(out_valid),
        .empty(out_empty), .almost_full(out_almost_full)
    );

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            rd_en_q   <= 1'b0;
            cfg_valid <= 1'b0;
        end else begin
            rd_en_q   <= cfg_rd_en;
            cfg_valid <= out_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        cfg_out <= out_dout;
    end

endmodule

`default_nettype wire

//--- source/cond_field_assembler.sv
/*
 * Condition field assembler
 * Decodes captured setup words into the filter condition fields by slot
 */
`timescale 1ns/1ns
`default_nettype none

module cond_field_assembler
    import cond_cfg_pkg::*;
(
    input  logic                 ap_clk,
    input  mem_word_t            word,
    input  logic [CFG_WORDS-1:0] slot,
    input  logic                 capture,
    input  logic                 complete,
    output logic                 cfg_push,
    output cond_cfg_t            cfg
);

    mem_word_t word_q;
    cond_cfg_t fields_q;
    cond_cfg_t fields_next;

    // Aligns the FIFO word with capture and slot
    always_ff @(posedge ap_clk) begin
        word_q <= word;
    end

    // ------------------------------------------------------------------------
    // Field decode
    // ------------------------------------------------------------------------
    always_comb begin
        fields_next = fields_q;
        if (capture) begin
            if (slot[0]) begin
                fields_next.filter_op = filter_op_e'(word_q[3:0]);
            end
            if (slot[1]) begin
                fields_next.filter_mask = word_q[NUM_FIELDS-1:0];
            end
            if (slot[2]) begin
                fields_next.const_mask = word_q[NUM_FIELDS-1:0];
            end
            if (slot[3]) begin
                fields_next.const_value = word_q;
            end
            if (slot[4]) begin
                fields_next.ops_mask = word_q[NUM_FIELDS*NUM_FIELDS-1:0];
            end
            if (slot[5]) begin
                fields_next.flags.break_flag       = word_q[0];
                fields_next.flags.filter_post      = word_q[1];
                fields_next.flags.continue_flag    = word_q[2];
                fields_next.flags.ternary_flag     = word_q[3];
                fields_next.flags.conditional_flag = word_q[4];
            end
        end
    end

    // Complete shares the edge with the last capture, so push the decoded view
    always_ff @(posedge ap_clk) begin
        fields_q <= fields_next;
        cfg_push <= complete;
        if (complete) begin
            cfg <= fields_next;
        end
    end

endmodule

`default_nettype wire

//--- source/cond_cfg_ctrl.sv
/*
 * Condition configuration control
 * Pops response words, tracks the one-hot window slot, raises capture and complete
 */
`timescale 1ns/1ns
`default_nettype none

module cond_cfg_ctrl #(
    parameter int SEQ_LEN = 8
) (
    input  logic               ap_clk,
    input  logic               rst,
    input  logic               resp_empty,
    input  logic               resp_valid,
    input  logic               resp_first,
    input  logic               out_almost_full,
    output logic               resp_pop,
    output logic [SEQ_LEN-1:0] slot,
    output logic               capture,
    output logic               complete
);

    localparam logic [SEQ_LEN-1:0] SLOT_FIRST = {{(SEQ_LEN-1){1'b0}}, 1'b1};

    logic [SEQ_LEN-1:0] slot_q;
    logic [SEQ_LEN-1:0] slot_next;
    logic               capture_q;
    logic               complete_q;

    // ------------------------------------------------------------------------
    // Pop decision
    // ------------------------------------------------------------------------
    // Hold off while the output FIFO fills or a configuration is being pushed
    assign resp_pop = ~resp_empty & ~out_almost_full & ~complete_q;

    // ------------------------------------------------------------------------
    // Slot tracking
    // ------------------------------------------------------------------------
    always_comb begin
        slot_next = slot_q;
        if (resp_valid) begin
            if (resp_first) begin
                // Window opening word restarts the sequence
                slot_next = SLOT_FIRST;
            end else begin
                slot_next = slot_q << 1;
            end
        end else if (complete_q) begin
            slot_next = '0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            slot_q     <= '0;
            capture_q  <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            slot_q     <= slot_next;
            capture_q  <= resp_valid;
            // Last slot filled
            complete_q <= resp_valid & slot_next[SEQ_LEN-1];
        end
    end

    assign slot     = slot_q;
    assign capture  = capture_q;
    assign complete = complete_q;

endmodule

`default_nettype wire

//--- source/sync_fifo.sv
/*
 * Synchronous FIFO
 * Circular buffer with registered read data, data-valid strobe and almost-full
 */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             ap_clk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             dout_valid,
    output logic             empty,
    output logic             almost_full
);

    // Free entries left when almost_full rises
    localparam int ALMOST_FULL_MARGIN = 4;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full        = (count == CNT_W'(DEPTH));
    assign empty       = (count == '0);
    assign almost_full = (count >= CNT_W'(DEPTH - ALMOST_FULL_MARGIN));

    // Writes when full and reads when empty are dropped
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- source/setup_word_filter.sv
/*
 * Setup word filter
 * Registers memory responses and keeps setup words inside this engine's window
 */
`timescale 1ns/1ns
`default_nettype none

module setup_word_filter
    import cond_cfg_pkg::*;
#(
    parameter int SEQ_LEN     = 8,
    parameter int ENGINE_SLOT = 0
) (
    input  logic        ap_clk,
    input  logic        rst,
    input  mem_packet_t mem_in,
    output logic        push,
    output mem_word_t   word,
    output logic        word_is_first
);

    // One extra bit so the window end never wraps
    localparam logic [ADDR_W:0] SEQ_BASE = (ADDR_W+1)'(ENGINE_SLOT * SEQ_LEN);
    localparam logic [ADDR_W:0] SEQ_END  = (ADDR_W+1)'(ENGINE_SLOT * SEQ_LEN + SEQ_LEN);

    logic               valid_q;
    buffer_kind_e       kind_q;
    addr_offset_t       offset_q;
    logic [SHIFT_W-1:0] shift_q;
    mem_word_t          data_q;
    addr_offset_t       seq_index;
    logic               is_setup;
    logic               in_window;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        kind_q   <= mem_in.kind;
        offset_q <= mem_in.offset;
        shift_q  <= mem_in.shift;
        data_q   <= mem_in.data;
    end

    // Sequence index of the word within the setup stream
    assign seq_index = offset_q >> shift_q;
    assign is_setup  = (kind_q == KIND_CU_SETUP) || (kind_q == KIND_ENGINE_SETUP);
    assign in_window = ({1'b0, seq_index} >= SEQ_BASE) && ({1'b0, seq_index} < SEQ_END);

    assign push          = valid_q & is_setup & in_window;
    assign word          = data_q;
    assign word_is_first = ({1'b0, seq_index} == SEQ_BASE);

endmodule

`default_nettype wire

//--- source/cond_cfg_pkg.sv
/*
 * Filter condition configuration types
 * Widths, field types, memory packet and condition configuration structs
 */
`default_nettype none

package cond_cfg_pkg;

    localparam int DATA_W     = 32;
    localparam int NUM_FIELDS = 4;
    localparam int ADDR_W     = 16;
    localparam int SHIFT_W    = 4;
    localparam int CFG_WORDS  = 6;

    typedef logic [DATA_W-1:0]                mem_word_t;
    typedef logic [ADDR_W-1:0]                addr_offset_t;
    typedef logic [NUM_FIELDS-1:0]            field_mask_t;
    typedef logic [NUM_FIELDS*NUM_FIELDS-1:0] ops_mask_t;

    typedef enum logic [1:0] {
        KIND_OTHER        = 2'd0,
        KIND_CU_SETUP     = 2'd1,
        KIND_ENGINE_SETUP = 2'd2
    } buffer_kind_e;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_EQ  = 4'd1,
        OP_NE  = 4'd2,
        OP_LT  = 4'd3,
        OP_GT  = 4'd4,
        OP_LE  = 4'd5,
        OP_GE  = 4'd6
    } filter_op_e;

    // Response word as it arrives from memory
    typedef struct packed {
        logic                 valid;
        buffer_kind_e         kind;
        addr_offset_t         offset;
        logic [SHIFT_W-1:0]   shift;
        mem_word_t            data;
    } mem_packet_t;

    typedef struct packed {
        logic break_flag;
        logic filter_post;
        logic continue_flag;
        logic ternary_flag;
        logic conditional_flag;
    } cond_flags_t;

    typedef struct packed {
        filter_op_e  filter_op;
        field_mask_t filter_mask;
        field_mask_t const_mask;
        mem_word_t   const_value;
        ops_mask_t   ops_mask;
        cond_flags_t flags;
    } cond_cfg_t;

endpackage

`default_nettype wire
